/* verilog.f */
+incdir+.
fetch_pkg.sv
insn_predecode.sv
icache_arrays.sv
fetch_control.sv
fetch_queue.sv
l1i_fetch.sv
tb_l1i_fetch.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -j 0 \
   --top-module tb_l1i_fetch -f verilog.f -o sim_tb_l1i_fetch
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/sim_tb_l1i_fetch
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
   exit "$status"
fi

echo "simulation finished"
exit 0

/* tb_l1i_fetch.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module tb_l1i_fetch;

   localparam int TOTAL_ENTRIES = 2000;
   localparam int NUM_RESTARTS = 20;
   localparam int NUM_FLUSHES = 3;   // the one after reset plus two mid-stream
   localparam int CYCLE_LIMIT = 40 * TOTAL_ENTRIES + 20 * NUM_FLUSHES;
   localparam int TAG_LO = `ICACHE_LG_SETS + `ICACHE_LG_LINE_BYTES;

   logic clk = 1'b0;
   logic reset, restart_valid, flush_req, insn_ack, mem_rsp_valid;
   logic [`ICACHE_ADDR_W-1:0] restart_pc;
   logic [`ICACHE_LINE_W-1:0] mem_rsp_data;
   logic restart_ack, flush_complete, insn_valid, insn_pred, mem_req_valid;
   logic [`ICACHE_ADDR_W-1:0] insn_pc, insn_target, mem_req_addr;
   logic [31:0] insn_data;

   logic [31:0] mem_words [256];          // indexed by address bits 9:2
   logic line_valid [1 << `ICACHE_LG_SETS];
   logic [`ICACHE_TAG_W-1:0] line_tag [1 << `ICACHE_LG_SETS];
   logic rsp_busy, restart_pending, flush_busy, unit_idle, in_slot;
   logic [31:0] req_addr, exp_pc, slot_target;
   int rsp_wait, cycles, checked, restarts_done, flushes_issued, flushes_done;
   int next_restart;

   l1i_fetch l1i_fetch_inst
     (
      .clk            (clk),
      .reset          (reset),
      .restart_valid  (restart_valid),
      .restart_pc     (restart_pc),
      .flush_req      (flush_req),
      .insn_ack       (insn_ack),
      .mem_rsp_valid  (mem_rsp_valid),
      .mem_rsp_data   (mem_rsp_data),
      .restart_ack    (restart_ack),
      .flush_complete (flush_complete),
      .insn_valid     (insn_valid),
      .insn_pc        (insn_pc),
      .insn_data      (insn_data),
      .insn_pred      (insn_pred),
      .insn_target    (insn_target),
      .mem_req_valid  (mem_req_valid),
      .mem_req_addr   (mem_req_addr)
      );

   always #5 clk = ~clk;

   task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
      if (got !== expected)
      begin
         $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
         $display("RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // jumps, unconditional and likely branches are the taken kinds
   function automatic logic predicted_taken(input logic [31:0] w);
      logic [4:0] rs;
      logic [4:0] rt;
      logic t;
      rs = w[25:21];
      rt = w[20:16];
      case (w[31:26])
         6'd2, 6'd3:                  t = 1'b1;
         6'd4:                        t = (rs == 5'd0) && (rt == 5'd0);
         6'd20, 6'd21, 6'd22, 6'd23:  t = 1'b1;
         6'd1:                        t = (rt == 5'd2) || (rt == 5'd3) ||
                                          (rt == 5'd17 && rs == 5'd0);
         6'd17:                       t = (rs == 5'd8) && w[17];
         default:                     t = 1'b0;
      endcase
      return t;
   endfunction

   function automatic logic [31:0] branch_dest(input logic [31:0] pc, input logic [31:0] w);
      logic [31:0] pc4;
      pc4 = pc + 32'd4;
      if (w[31:26] == 6'd2 || w[31:26] == 6'd3)
         return {pc4[31:28], w[25:0], 2'b00};
      return pc4 + {{14{w[15]}}, w[15:0], 2'b00};
   endfunction

   task automatic fill_memory();
      int r;
      logic [31:0] rest;
      logic [15:0] imm;
      logic [5:0] op;
      for (int i = 0; i < 256; i++)
      begin
         r = $urandom % 100;
         rest = $urandom;
         imm = {{9{rest[6]}}, rest[6:0]};  // short branches keep lines reused
         if (r < 60)
         begin
            case (rest[29:28])
               2'd0:    op = 6'd0;
               2'd1:    op = 6'd8;
               2'd2:    op = 6'd35;
               default: op = 6'd43;
            endcase
            mem_words[i] = {op, rest[25:0]};
         end
         else if (r < 70)
            mem_words[i] = {5'b00001, rest[26], 16'h0, rest[9:0]};  // j or jal
         else if (r < 80)
         begin
            case (rest[31:30])
               2'd0:    mem_words[i] = {6'd4, rest[25:21] | 5'd1, rest[20:16], imm};
               2'd1:    mem_words[i] = {rest[27] ? 6'd6 : (rest[26] ? 6'd7 : 6'd5),
                                        rest[25:16], imm};
               2'd2:    mem_words[i] = {6'd1, rest[25:21], 4'b0000, rest[16], imm};
               default: mem_words[i] = {6'd17, 5'd8, 4'b0000, rest[16], imm};
            endcase
         end
         else if (r < 90)
         begin
            case (rest[31:30])
               2'd0, 2'd1: mem_words[i] = {4'b0101, rest[27:26], rest[25:16], imm};
               2'd2:       mem_words[i] = {6'd1, rest[25:21], 4'b0001, rest[16], imm};
               default:    mem_words[i] = {6'd17, 5'd8, 4'b0001, rest[16], imm};
            endcase
         end
         else if (rest[31])
            mem_words[i] = {6'd4, 10'd0, imm};          // beq zero, zero
         else
            mem_words[i] = {6'd1, 5'd0, 5'd17, imm};    // bal
      end
   endtask

   // memory responder and direct-mapped cache model
   task automatic serve_memory();
      logic [`ICACHE_LG_SETS-1:0] set;
      logic [7:0] base;
      if (mem_req_valid)
      begin
         set = mem_req_addr[TAG_LO-1:`ICACHE_LG_LINE_BYTES];
         check_equal(rsp_busy, 1'b0, "mem_req_valid with a request outstanding");
         check_equal(mem_req_addr[`ICACHE_LG_LINE_BYTES-1:0], 0, "mem_req_addr alignment");
         check_equal(line_valid[set] && line_tag[set] == mem_req_addr[31:TAG_LO], 1'b0,
                     "request for a line already cached");
         req_addr = mem_req_addr;
         rsp_busy = 1'b1;
         rsp_wait = 1 + ($urandom % 8);
      end
      else if (rsp_busy)
      begin
         rsp_wait--;
         if (rsp_wait == 0)
         begin
            base = req_addr[9:2];
            for (int i = 0; i < `ICACHE_WORDS_PER_LINE; i++)
               mem_rsp_data[32*i +: 32] = mem_words[base + i];
            mem_rsp_valid = 1'b1;
            set = req_addr[TAG_LO-1:`ICACHE_LG_LINE_BYTES];
            line_valid[set] = 1'b1;
            line_tag[set] = req_addr[31:TAG_LO];
            rsp_busy = 1'b0;
         end
      end
   endtask

   task automatic check_entry();
      logic [31:0] w;
      logic [31:0] exp_target;
      logic [31:0] nxt;
      logic exp_pred;
      check_equal(insn_pc, exp_pc, "insn_pc");
      w = mem_words[exp_pc[9:2]];
      check_equal(insn_data, w, "insn_data");
      exp_pred = 1'b0;
      exp_target = exp_pc + 32'd4;
      nxt = exp_pc + 32'd4;
      if (in_slot)
      begin
         exp_target = slot_target;   // delay slot carries the branch target
         nxt = slot_target;
         in_slot = 1'b0;
      end
      else if (predicted_taken(w))
      begin
         exp_pred = 1'b1;
         slot_target = branch_dest(exp_pc, w);
         in_slot = 1'b1;
      end
      check_equal(insn_pred, exp_pred, "insn_pred");
      check_equal(insn_target, exp_target, "insn_target");
      exp_pc = nxt;
      checked++;
   endtask

   task automatic run_cycle();
      @(negedge clk);
      cycles++;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("RESULT: FAIL");
         $fatal(1, "timeout");
      end
      restart_valid = 1'b0;
      flush_req = 1'b0;
      mem_rsp_valid = 1'b0;
      serve_memory();
      if (restart_ack)
      begin
         check_equal(restart_pending, 1'b1, "restart_ack without a restart");
         restart_pending = 1'b0;
         unit_idle = 1'b0;
         exp_pc = restart_pc;  // stream model starts over
         in_slot = 1'b0;
      end
      if (flush_complete)
      begin
         check_equal(flush_busy, 1'b1, "flush_complete without a flush");
         flush_busy = 1'b0;
         unit_idle = 1'b1;
         flushes_done++;
         for (int s = 0; s < (1 << `ICACHE_LG_SETS); s++)
            line_valid[s] = 1'b0;
      end
      if (unit_idle)
         check_equal(insn_valid, 1'b0, "insn_valid before a restart");
      insn_ack = ($urandom % 100) < 70;
      if (insn_valid && insn_ack)
         check_entry();
   endtask

   task automatic issue_restart();
      restart_valid = 1'b1;
      restart_pc = $urandom & 32'h0000_0ffc;
      restart_pending = 1'b1;
   endtask

   initial
   begin
      void'($urandom(32'h9740b1c4));
      reset = 1'b1;
      restart_valid = 1'b0;
      restart_pc = '0;
      flush_req = 1'b0;
      insn_ack = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp_data = '0;
      rsp_busy = 1'b0;
      restart_pending = 1'b0;
      flush_busy = 1'b0;
      unit_idle = 1'b0;
      in_slot = 1'b0;
      exp_pc = '0;
      slot_target = '0;
      req_addr = '0;
      rsp_wait = 0;
      cycles = 0;
      checked = 0;
      restarts_done = 0;
      flushes_done = 0;
      for (int s = 0; s < (1 << `ICACHE_LG_SETS); s++)
         line_valid[s] = 1'b0;
      fill_memory();

      repeat (8) @(negedge clk);
      check_equal(insn_valid, 1'b0, "insn_valid after reset");
      check_equal(mem_req_valid, 1'b0, "mem_req_valid after reset");
      check_equal(restart_ack, 1'b0, "restart_ack after reset");
      check_equal(flush_complete, 1'b0, "flush_complete after reset");
      reset = 1'b0;

      // first flush sets every valid bit to a known state
      run_cycle();
      flush_req = 1'b1;
      flush_busy = 1'b1;
      flushes_issued = 1;
      while (flush_busy)
         run_cycle();
      repeat (12) run_cycle();

      next_restart = 30 + ($urandom % 60);
      while (checked < TOTAL_ENTRIES)
      begin
         run_cycle();
         if (!restart_pending && !flush_busy)
         begin
            if (unit_idle)
               issue_restart();
            else if (flushes_issued < NUM_FLUSHES && checked >= 650 * flushes_issued)
            begin
               flush_req = 1'b1;
               flush_busy = 1'b1;
               flushes_issued++;
            end
            else if (restarts_done < NUM_RESTARTS && checked >= next_restart)
            begin
               issue_restart();
               restarts_done++;
               next_restart = checked + 30 + ($urandom % 60);
            end
         end
      end
      check_equal(restarts_done, NUM_RESTARTS, "mid-stream restarts issued");
      check_equal(flushes_done, NUM_FLUSHES, "flush_complete pulses");
      $display("RESULT: PASS");
      $finish;
   end

endmodule

/* l1i_fetch.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module l1i_fetch
  (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        restart_valid,
   input  logic [`ICACHE_ADDR_W-1:0]   restart_pc,
   input  logic                        flush_req,
   input  logic                        insn_ack,
   input  logic                        mem_rsp_valid,
   input  logic [`ICACHE_LINE_W-1:0]   mem_rsp_data,
   output logic                        restart_ack,
   output logic                        flush_complete,
   output logic                        insn_valid,
   output logic [`ICACHE_ADDR_W-1:0]   insn_pc,
   output logic [31:0]                 insn_data,
   output logic                        insn_pred,
   output logic [`ICACHE_ADDR_W-1:0]   insn_target,
   output logic                        mem_req_valid,
   output logic [`ICACHE_ADDR_W-1:0]   mem_req_addr
   );
   import fetch_pkg::*;

   jump_t [`ICACHE_WORDS_PER_LINE-1:0] fill_kinds, rd_kinds;
   logic [`ICACHE_LG_SETS-1:0] lookup_idx, flush_idx;
   logic [`ICACHE_TAG_W-1:0] rd_tag;
   logic [`ICACHE_LINE_W-1:0] rd_line;
   logic [`ICACHE_ADDR_W-1:0] push_pc, push_target;
   logic [31:0] push_data;
   logic rd_valid, fill, flush_wr, push, push_pred, clear, queue_full;

   // refill line is predecoded on its way into the arrays
   insn_predecode insn_predecode_inst
     (
      .line  (mem_rsp_data),
      .kinds (fill_kinds)
      );

   icache_arrays icache_arrays_inst
     (
      .clk        (clk),
      .lookup_idx (lookup_idx),
      .fill       (fill),
      .fill_addr  (mem_req_addr),
      .fill_line  (mem_rsp_data),
      .fill_kinds (fill_kinds),
      .flush_wr   (flush_wr),
      .flush_idx  (flush_idx),
      .rd_valid   (rd_valid),
      .rd_tag     (rd_tag),
      .rd_line    (rd_line),
      .rd_kinds   (rd_kinds)
      );

   fetch_control fetch_control_inst
     (
      .clk            (clk),
      .reset          (reset),
      .restart_valid  (restart_valid),
      .restart_pc     (restart_pc),
      .flush_req      (flush_req),
      .mem_rsp_valid  (mem_rsp_valid),
      .rd_valid       (rd_valid),
      .rd_tag         (rd_tag),
      .rd_line        (rd_line),
      .rd_kinds       (rd_kinds),
      .queue_full     (queue_full),
      .restart_ack    (restart_ack),
      .flush_complete (flush_complete),
      .mem_req_valid  (mem_req_valid),
      .mem_req_addr   (mem_req_addr),
      .lookup_idx     (lookup_idx),
      .fill           (fill),
      .flush_wr       (flush_wr),
      .flush_idx      (flush_idx),
      .push           (push),
      .push_pc        (push_pc),
      .push_data      (push_data),
      .push_pred      (push_pred),
      .push_target    (push_target),
      .clear          (clear)
      );

   fetch_queue fetch_queue_inst
     (
      .clk         (clk),
      .reset       (reset),
      .clear       (clear),
      .push        (push),
      .push_pc     (push_pc),
      .push_data   (push_data),
      .push_pred   (push_pred),
      .push_target (push_target),
      .insn_ack    (insn_ack),
      .queue_full  (queue_full),
      .insn_valid  (insn_valid),
      .insn_pc     (insn_pc),
      .insn_data   (insn_data),
      .insn_pred   (insn_pred),
      .insn_target (insn_target)
      );

endmodule

/* fetch_queue.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_queue
  (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      clear,
   input  logic                      push,
   input  logic [`ICACHE_ADDR_W-1:0] push_pc,
   input  logic [31:0]               push_data,
   input  logic                      push_pred,
   input  logic [`ICACHE_ADDR_W-1:0] push_target,
   input  logic                      insn_ack,
   output logic                      queue_full,
   output logic                      insn_valid,
   output logic [`ICACHE_ADDR_W-1:0] insn_pc,
   output logic [31:0]               insn_data,
   output logic                      insn_pred,
   output logic [`ICACHE_ADDR_W-1:0] insn_target
   );

   localparam int DEPTH = 1 << `FQ_LG_ENTRIES;

   logic [`FQ_LG_ENTRIES:0] r_head, r_tail;  // extra bit tells full from empty
   logic [`FQ_LG_ENTRIES-1:0] head_slot, tail_slot;

   logic [`ICACHE_ADDR_W-1:0] pc_q [DEPTH];
   logic [31:0]               data_q [DEPTH];
   logic                      pred_q [DEPTH];
   logic [`ICACHE_ADDR_W-1:0] target_q [DEPTH];

   assign head_slot = r_head[`FQ_LG_ENTRIES-1:0];
   assign tail_slot = r_tail[`FQ_LG_ENTRIES-1:0];
   assign insn_valid = (r_head != r_tail);
   assign queue_full = (r_head[`FQ_LG_ENTRIES] != r_tail[`FQ_LG_ENTRIES]) &&
                       (head_slot == tail_slot);

   assign insn_pc = pc_q[head_slot];
   assign insn_data = data_q[head_slot];
   assign insn_pred = pred_q[head_slot];
   assign insn_target = target_q[head_slot];

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         r_head <= '0;
         r_tail <= '0;
      end
      else
      begin
         if (push)
            r_tail <= r_tail + 'd1;
         if (insn_ack && insn_valid)
            r_head <= r_head + 'd1;  // pop shows at the next edge
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         pc_q[tail_slot] <= push_pc;
         data_q[tail_slot] <= push_data;
         pred_q[tail_slot] <= push_pred;
         target_q[tail_slot] <= push_target;
      end
   end

endmodule

/* fetch_control.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_control
  (
   input  logic                                          clk,
   input  logic                                          reset,
   input  logic                                          restart_valid,
   input  logic [`ICACHE_ADDR_W-1:0]                     restart_pc,
   input  logic                                          flush_req,
   input  logic                                          mem_rsp_valid,
   input  logic                                          rd_valid,
   input  logic [`ICACHE_TAG_W-1:0]                      rd_tag,
   input  logic [`ICACHE_LINE_W-1:0]                     rd_line,
   input  fetch_pkg::jump_t [`ICACHE_WORDS_PER_LINE-1:0] rd_kinds,
   input  logic                                          queue_full,
   output logic                                          restart_ack,
   output logic                                          flush_complete,
   output logic                                          mem_req_valid,
   output logic [`ICACHE_ADDR_W-1:0]                     mem_req_addr,
   output logic [`ICACHE_LG_SETS-1:0]                    lookup_idx,
   output logic                                          fill,
   output logic                                          flush_wr,
   output logic [`ICACHE_LG_SETS-1:0]                    flush_idx,
   output logic                                          push,
   output logic [`ICACHE_ADDR_W-1:0]                     push_pc,
   output logic [31:0]                                   push_data,
   output logic                                          push_pred,
   output logic [`ICACHE_ADDR_W-1:0]                     push_target,
   output logic                                          clear
   );
   import fetch_pkg::*;

   localparam int IDX_LO = `ICACHE_LG_LINE_BYTES;
   localparam int TAG_LO = `ICACHE_LG_LINE_BYTES + `ICACHE_LG_SETS;
   localparam logic [`ICACHE_LG_SETS-1:0] LAST_SET = '1;

   typedef enum logic [2:0]
   {
      IDLE, ACTIVE, INJECT_RELOAD, RELOAD_TURNAROUND, FLUSH, WAIT_NOT_FULL
   } state_t;

   state_t r_state, n_state;
   logic [`ICACHE_ADDR_W-1:0] r_pc, n_pc;               // next pc to look up
   logic [`ICACHE_ADDR_W-1:0] r_cache_pc, n_cache_pc;   // pc of the pending read
   logic [`ICACHE_ADDR_W-1:0] r_miss_pc, n_miss_pc;
   logic [`ICACHE_ADDR_W-1:0] r_target, n_target;       // branch target for the delay slot
   logic [`ICACHE_ADDR_W-1:0] r_mem_req_addr, n_mem_req_addr;
   logic [`ICACHE_LG_SETS-1:0] r_flush_idx, n_flush_idx;
   logic r_req, n_req;
   logic r_delay_slot, n_delay_slot;
   logic r_restart_req, n_restart_req;
   logic r_flush_req, n_flush_req;
   logic r_restart_ack, n_restart_ack;
   logic r_flush_complete, n_flush_complete;
   logic r_mem_req_valid, n_mem_req_valid;

   insn_word_t word;
   jump_t kind;
   logic [`ICACHE_ADDR_W-1:0] pc4, br_target, j_target;
   logic hit, miss, taken, redirect_ok;

   always_comb
   begin
      word = rd_line[32*r_cache_pc[IDX_LO-1:2] +: 32];
      kind = rd_kinds[r_cache_pc[IDX_LO-1:2]];
      pc4 = r_cache_pc + 'd4;
      br_target = pc4 + {{(`ICACHE_ADDR_W-18){word.i.imm[15]}}, word.i.imm, 2'b00};
      j_target = {pc4[`ICACHE_ADDR_W-1:28], word.j.index, 2'b00};
      hit = r_req && rd_valid && (rd_tag == r_cache_pc[`ICACHE_ADDR_W-1:TAG_LO]);
      miss = r_req && !hit;
      // conditional branches fall through, a delay slot is never predicted
      taken = !r_delay_slot && (kind == JUMP || kind == UNCOND_BR || kind == LIKELY_BR);
   end

   // restart and flush wait while a refill is outstanding
   assign redirect_ok = (r_state != INJECT_RELOAD) && (r_state != FLUSH);

   assign lookup_idx = (r_state == RELOAD_TURNAROUND || r_state == WAIT_NOT_FULL) ?
                       r_miss_pc[TAG_LO-1:IDX_LO] : r_pc[TAG_LO-1:IDX_LO];
   assign fill = (r_state == INJECT_RELOAD) && mem_rsp_valid;
   assign flush_wr = (r_state == FLUSH);
   assign flush_idx = r_flush_idx;
   assign push_pc = r_cache_pc;
   assign push_data = word;
   assign push_pred = taken;
   assign push_target = r_delay_slot ? r_target : pc4;
   assign restart_ack = r_restart_ack;
   assign flush_complete = r_flush_complete;
   assign mem_req_valid = r_mem_req_valid;
   assign mem_req_addr = r_mem_req_addr;

   always_comb
   begin
      n_state = r_state;
      n_pc = r_pc;
      n_cache_pc = r_cache_pc;
      n_miss_pc = r_miss_pc;
      n_target = r_target;
      n_mem_req_addr = r_mem_req_addr;
      n_flush_idx = r_flush_idx;
      n_req = 1'b0;
      n_delay_slot = r_delay_slot;
      n_restart_req = r_restart_req | restart_valid;
      n_flush_req = r_flush_req | flush_req;
      n_restart_ack = 1'b0;
      n_flush_complete = 1'b0;
      n_mem_req_valid = 1'b0;
      push = 1'b0;
      clear = 1'b0;

      if (redirect_ok && n_flush_req)
      begin
         n_flush_req = 1'b0;
         n_flush_idx = '0;
         n_delay_slot = 1'b0;
         clear = 1'b1;
         n_state = FLUSH;
      end
      else if (redirect_ok && n_restart_req)
      begin
         n_restart_req = 1'b0;
         n_restart_ack = 1'b1;
         n_pc = restart_pc;
         n_delay_slot = 1'b0;
         clear = 1'b1;
         n_state = ACTIVE;
      end
      else
      begin
         case (r_state)
            ACTIVE:
            begin
               n_cache_pc = r_pc;
               n_req = 1'b1;
               n_pc = r_pc + 'd4;
               if (miss)
               begin
                  n_req = 1'b0;
                  n_pc = r_pc;  // re-issued after the refill
                  n_miss_pc = r_cache_pc;
                  n_mem_req_addr = {r_cache_pc[`ICACHE_ADDR_W-1:IDX_LO], {IDX_LO{1'b0}}};
                  n_mem_req_valid = 1'b1;
                  n_state = INJECT_RELOAD;
               end
               else if (hit && queue_full)
               begin
                  n_req = 1'b0;
                  n_pc = r_pc;
                  n_miss_pc = r_cache_pc;
                  n_state = WAIT_NOT_FULL;
               end
               else if (hit)
               begin
                  push = 1'b1;
                  n_delay_slot = taken;
                  if (taken)
                  begin
                     // delay slot lookup is already in flight
                     n_target = (kind == JUMP) ? j_target : br_target;
                     n_pc = n_target;
                  end
               end
            end
            INJECT_RELOAD:
            begin
               if (mem_rsp_valid)
               begin
                  n_state = RELOAD_TURNAROUND;
               end
            end
            RELOAD_TURNAROUND, WAIT_NOT_FULL:
            begin
               if (!queue_full)
               begin
                  n_cache_pc = r_miss_pc;
                  n_req = 1'b1;
                  n_state = ACTIVE;
               end
            end
            FLUSH:
            begin
               n_flush_idx = r_flush_idx + 'd1;
               if (r_flush_idx == LAST_SET)
               begin
                  n_flush_complete = 1'b1;
                  n_state = IDLE;  // stays here until a restart
               end
            end
            default:
            begin
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= IDLE;
         r_req <= 1'b0;
         r_delay_slot <= 1'b0;
         r_restart_req <= 1'b0;
         r_flush_req <= 1'b0;
         r_restart_ack <= 1'b0;
         r_flush_complete <= 1'b0;
         r_mem_req_valid <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_req <= n_req;
         r_delay_slot <= n_delay_slot;
         r_restart_req <= n_restart_req;
         r_flush_req <= n_flush_req;
         r_restart_ack <= n_restart_ack;
         r_flush_complete <= n_flush_complete;
         r_mem_req_valid <= n_mem_req_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      r_pc <= n_pc;
      r_cache_pc <= n_cache_pc;
      r_miss_pc <= n_miss_pc;
      r_target <= n_target;
      r_mem_req_addr <= n_mem_req_addr;  // held until the response
      r_flush_idx <= n_flush_idx;
   end

endmodule

/* icache_arrays.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module icache_arrays
  (
   input  logic                                          clk,
   input  logic [`ICACHE_LG_SETS-1:0]                    lookup_idx,
   input  logic                                          fill,
   input  logic [`ICACHE_ADDR_W-1:0]                     fill_addr,
   input  logic [`ICACHE_LINE_W-1:0]                     fill_line,
   input  fetch_pkg::jump_t [`ICACHE_WORDS_PER_LINE-1:0] fill_kinds,
   input  logic                                          flush_wr,
   input  logic [`ICACHE_LG_SETS-1:0]                    flush_idx,
   output logic                                          rd_valid,
   output logic [`ICACHE_TAG_W-1:0]                      rd_tag,
   output logic [`ICACHE_LINE_W-1:0]                     rd_line,
   output fetch_pkg::jump_t [`ICACHE_WORDS_PER_LINE-1:0] rd_kinds
   );
   import fetch_pkg::*;

   localparam int SETS = 1 << `ICACHE_LG_SETS;
   localparam int IDX_LO = `ICACHE_LG_LINE_BYTES;
   localparam int TAG_LO = `ICACHE_LG_LINE_BYTES + `ICACHE_LG_SETS;

   logic                               valid_mem [SETS];
   logic [`ICACHE_TAG_W-1:0]           tag_mem [SETS];
   logic [`ICACHE_LINE_W-1:0]          line_mem [SETS];
   jump_t [`ICACHE_WORDS_PER_LINE-1:0] kind_mem [SETS];  // predecode per word

   logic [`ICACHE_LG_SETS-1:0] fill_idx;

   assign fill_idx = fill_addr[TAG_LO-1:IDX_LO];

   // refill writes the whole set in the response cycle
   always_ff @(posedge clk)
   begin
      if (fill)
      begin
         tag_mem[fill_idx]  <= fill_addr[`ICACHE_ADDR_W-1:TAG_LO];
         line_mem[fill_idx] <= fill_line;
         kind_mem[fill_idx] <= fill_kinds;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fill)
      begin
         valid_mem[fill_idx] <= 1'b1;
      end
      else if (flush_wr)
      begin
         valid_mem[flush_idx] <= 1'b0;  // one set per sweep cycle
      end
   end

   // registered read, result one cycle after lookup_idx
   always_ff @(posedge clk)
   begin
      rd_valid <= valid_mem[lookup_idx];
      rd_tag   <= tag_mem[lookup_idx];
      rd_line  <= line_mem[lookup_idx];
      rd_kinds <= kind_mem[lookup_idx];
   end

endmodule

/* insn_predecode.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module insn_predecode
  (
   input  logic [`ICACHE_LINE_W-1:0]                     line,
   output fetch_pkg::jump_t [`ICACHE_WORDS_PER_LINE-1:0] kinds
   );
   import fetch_pkg::*;

   function automatic jump_t classify(insn_word_t w);
      jump_t k;
      k = NOT_CFLOW;
      case (w.j.opcode)
         6'd1:  // regimm group
         begin
            case (w.i.rt)
               5'd0, 5'd1: k = COND_BR;
               5'd2, 5'd3: k = LIKELY_BR;
               5'd17:      k = (w.i.rs == 5'd0) ? UNCOND_BR : NOT_CFLOW;  // bal
               default:    k = NOT_CFLOW;
            endcase
         end
         6'd2, 6'd3:
            k = JUMP;
         6'd4:
            k = (w.i.rs == 5'd0 && w.i.rt == 5'd0) ? UNCOND_BR : COND_BR;
         6'd5, 6'd6, 6'd7:
            k = COND_BR;
         6'd17:
         begin
            // bc1f/bc1t, bit 17 marks the likely forms
            if (w.i.rs == 5'd8)
            begin
               k = w.i.rt[1] ? LIKELY_BR : COND_BR;
            end
         end
         6'd20, 6'd21, 6'd22, 6'd23:
            k = LIKELY_BR;
         default:
            k = NOT_CFLOW;
      endcase
      return k;
   endfunction

   always_comb
   begin
      for (int i = 0; i < `ICACHE_WORDS_PER_LINE; i++)
      begin
         kinds[i] = classify(line[32*i +: 32]);  // word i, no byte swap
      end
   end

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

   // control-flow kind stored next to each cached word
   typedef enum logic [2:0]
   {
      NOT_CFLOW = 3'd0,
      COND_BR   = 3'd1,   // predicted not-taken
      LIKELY_BR = 3'd2,
      UNCOND_BR = 3'd3,
      JUMP      = 3'd4
   } jump_t;

   typedef struct packed
   {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
   } itype_t;

   typedef struct packed
   {
      logic [5:0]  opcode;
      logic [25:0] index;
   } jtype_t;

   // one instruction word, seen as i-type or j-type
   typedef union packed
   {
      itype_t i;
      jtype_t j;
   } insn_word_t;

endpackage

/* fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// pc and memory address width
`define ICACHE_ADDR_W 32

// direct-mapped geometry, 16 sets of 16-byte lines
`define ICACHE_LG_SETS 4
`define ICACHE_LG_LINE_BYTES 4
`define ICACHE_WORDS_PER_LINE 4
`define ICACHE_LINE_W 128

// tag is what is left above the set and offset bits
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_LG_SETS - `ICACHE_LG_LINE_BYTES)

// fetch queue depth, 8 entries
`define FQ_LG_ENTRIES 3

`endif
